/* design/gke_pkg.sv */
// generic key extractor, shared definitions
// payload types, packet kinds, captured header fields and the
// bit positions used in the md, the phv and the lookup key
`default_nettype none

package gke_pkg;

    typedef logic [255:0]  md_t;
    typedef logic [1023:0] phv_t;
    typedef logic [511:0]  key_t;
    typedef logic [7:0]    mid_t;

    // kind_other doubles as the idle value after reset
    typedef enum logic [2:0] {
        kind_other   = 3'd0,
        kind_ipv4_l4 = 3'd1,
        kind_ipv4    = 3'd2,
        kind_arp     = 3'd3,
        kind_ipv6_l4 = 3'd4,
        kind_ipv6    = 3'd5
    } pkt_kind_e;

    typedef struct packed {
        logic [47:0]  dmac;
        logic [47:0]  smac;
        logic [15:0]  tci;
        logic [15:0]  eth_type;
        logic [7:0]   ip_proto;
        logic [7:0]   tos;
        logic [7:0]   ttl;
        logic [1:0]   frag;
        logic [5:0]   inport;
        logic [31:0]  sip;
        logic [31:0]  dip;
        logic [127:0] src_ip;
        logic [127:0] dst_ip;
        logic [31:0]  label;
        logic [15:0]  sport;
        logic [15:0]  dport;
        logic [15:0]  flag;
        logic [47:0]  sha;
        logic [47:0]  tha;
    } hdr_fields_t;

    // **********************************************************
    // md fields, lsb positions
    // **********************************************************
    localparam int md_type_lsb   = 72;
    localparam int md_mid_lsb    = 80;
    localparam int md_inport_lsb = 120;

    // **********************************************************
    // phv fields, msb positions
    // **********************************************************
    // ethernet part, same for every kind
    localparam int phv_dmac_msb     = 1023;
    localparam int phv_smac_msb     = 975;
    localparam int phv_eth_type_msb = 927;
    localparam int phv_tci_msb      = 911;
    // ipv4
    localparam int phv_v4_tos_msb   = 903;
    localparam int phv_v4_frag_msb  = 862;
    localparam int phv_v4_ttl_msb   = 847;
    localparam int phv_v4_proto_msb = 839;
    localparam int phv_v4_sip_msb   = 815;
    localparam int phv_v4_dip_msb   = 783;
    localparam int phv_v4_sport_msb = 751;
    localparam int phv_v4_dport_msb = 735;
    localparam int phv_v4_flag_msb  = 655;
    // arp
    localparam int phv_arp_proto_msb = 855;
    localparam int phv_arp_sha_msb   = 847;
    localparam int phv_arp_sip_msb   = 799;
    localparam int phv_arp_tha_msb   = 767;
    localparam int phv_arp_dip_msb   = 719;
    // ipv6
    localparam int phv_v6_tos_msb   = 907;
    localparam int phv_v6_label_msb = 899;
    localparam int phv_v6_proto_msb = 863;
    localparam int phv_v6_ttl_msb   = 855;
    localparam int phv_v6_src_msb   = 847;
    localparam int phv_v6_dst_msb   = 719;
    localparam int phv_v6_sport_msb = 591;
    localparam int phv_v6_dport_msb = 575;
    localparam int phv_v6_flag_msb  = 495;

    // **********************************************************
    // key layout, lsb offsets
    // **********************************************************
    localparam int key_dmac_lsb     = 0;
    localparam int key_smac_lsb     = 48;
    localparam int key_tci_lsb      = 96;
    localparam int key_eth_type_lsb = 112;
    localparam int key_proto_lsb    = 128;
    localparam int key_tos_lsb      = 136;
    localparam int key_ttl_lsb      = 144;
    localparam int key_inport_lsb   = 152;
    localparam int key_frag_lsb     = 158;
    localparam int key_sip_lsb      = 160;
    localparam int key_dip_lsb      = 192;
    localparam int key_v4_sport_lsb = 224;
    localparam int key_v4_dport_lsb = 240;
    localparam int key_v4_flag_lsb  = 256;
    localparam int key_arp_sha_lsb  = 224;
    localparam int key_arp_tha_lsb  = 272;
    localparam int key_v6_src_lsb   = 160;
    localparam int key_v6_dst_lsb   = 288;
    localparam int key_v6_label_lsb = 416;
    localparam int key_v6_sport_lsb = 448;
    localparam int key_v6_dport_lsb = 464;

endpackage

`default_nettype wire

/* design/gke_ctrl.sv */
// key extractor control
// matches the md module id against this stage, decodes the type
// code into a packet kind, and carries the per-packet controls
// one cycle on to the key and forwarding stages
`default_nettype none

module gke_ctrl #(
    parameter gke_pkg::mid_t local_mid = 8'd2
) (
    input  wire                logic        clk,
    input  wire                logic        rst_n,
    input  wire gke_pkg::md_t               md,
    input  wire                logic        md_wr,
    input  wire                logic        phv_wr,
    input  wire                logic        down_md_alf,
    input  wire                logic        down_phv_alf,
    input  wire                logic        down_key_alf,
    output      logic                       md_alf,
    output      logic                       phv_alf,
    output      logic                       cap_en,
    output      gke_pkg::pkt_kind_e         cap_kind,
    output      logic                       s1_key_valid,
    output      gke_pkg::pkt_kind_e         s1_kind,
    output      logic                       s1_match
);
    import gke_pkg::*;

    logic [7:0] type_code;
    logic       matched;

    assign type_code = md[md_type_lsb +: 8];
    assign matched   = md_wr && (md[md_mid_lsb +: 8] == local_mid);

    // a key stall anywhere downstream holds off both inputs
    assign md_alf  = down_md_alf | down_key_alf;
    assign phv_alf = down_phv_alf | down_key_alf;

    // type code decode, no phv means nothing to extract
    always_comb begin
        cap_kind = kind_other;
        if (phv_wr) begin
            case (type_code)
                8'h01, 8'h07: cap_kind = kind_ipv4_l4;
                8'h02:        cap_kind = kind_ipv4;
                8'h03:        cap_kind = kind_arp;
                8'h81, 8'h83: cap_kind = kind_ipv6_l4;
                8'h82:        cap_kind = kind_ipv6;
                default:      cap_kind = kind_other;
            endcase
        end
    end

    assign cap_en = matched && (cap_kind != kind_other);

    // **********************************************************
    // stage 1 control registers
    // **********************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_key_valid <= 1'b0;
            s1_kind      <= kind_other;
            s1_match     <= 1'b0;
        end else begin
            s1_key_valid <= matched;
            s1_match     <= matched;
            // unmatched packets leave no kind behind
            s1_kind      <= matched ? cap_kind : kind_other;
        end
    end

endmodule

`default_nettype wire

/* design/gke_field_extract.sv */
// key extractor stage 1 datapath
// picks the header fields out of the phv at the positions of the
// decoded packet kind, plus the input port from the md, and holds
// them until the next packet addressed to this stage
`default_nettype none

module gke_field_extract (
    input  wire                logic        clk,
    input  wire                logic        rst_n,
    input  wire gke_pkg::md_t               md,
    input  wire gke_pkg::phv_t              phv,
    input  wire                logic        cap_en,
    input  wire gke_pkg::pkt_kind_e         cap_kind,
    output      gke_pkg::hdr_fields_t       fields
);
    import gke_pkg::*;

    hdr_fields_t nxt;

    always_comb begin
        // fields not used by this kind keep their old value
        nxt          = fields;
        nxt.dmac     = phv[phv_dmac_msb -: 48];
        nxt.smac     = phv[phv_smac_msb -: 48];
        nxt.tci      = phv[phv_tci_msb -: 16];
        nxt.eth_type = phv[phv_eth_type_msb -: 16];
        nxt.inport   = md[md_inport_lsb +: 6];
        case (cap_kind)
            kind_ipv4_l4, kind_ipv4: begin
                nxt.tos      = phv[phv_v4_tos_msb -: 8];
                nxt.frag     = phv[phv_v4_frag_msb -: 2];
                nxt.ttl      = phv[phv_v4_ttl_msb -: 8];
                nxt.ip_proto = phv[phv_v4_proto_msb -: 8];
                nxt.sip      = phv[phv_v4_sip_msb -: 32];
                nxt.dip      = phv[phv_v4_dip_msb -: 32];
                nxt.sport    = phv[phv_v4_sport_msb -: 16];
                nxt.dport    = phv[phv_v4_dport_msb -: 16];
                // only six tcp flag bits are parsed
                nxt.flag     = {10'b0, phv[phv_v4_flag_msb -: 6]};
            end
            kind_arp: begin
                nxt.tos      = 8'b0;
                nxt.ttl      = 8'b0;
                nxt.frag     = 2'b0;
                nxt.ip_proto = phv[phv_arp_proto_msb -: 8];
                nxt.sha      = phv[phv_arp_sha_msb -: 48];
                nxt.sip      = phv[phv_arp_sip_msb -: 32];
                nxt.tha      = phv[phv_arp_tha_msb -: 48];
                nxt.dip      = phv[phv_arp_dip_msb -: 32];
            end
            kind_ipv6_l4, kind_ipv6: begin
                nxt.tos      = phv[phv_v6_tos_msb -: 8];
                nxt.ip_proto = phv[phv_v6_proto_msb -: 8];
                nxt.ttl      = phv[phv_v6_ttl_msb -: 8];
                nxt.frag     = 2'b0;
                // 20-bit flow label
                nxt.label    = {12'b0, phv[phv_v6_label_msb -: 20]};
                nxt.src_ip   = phv[phv_v6_src_msb -: 128];
                nxt.dst_ip   = phv[phv_v6_dst_msb -: 128];
                nxt.sport    = phv[phv_v6_sport_msb -: 16];
                nxt.dport    = phv[phv_v6_dport_msb -: 16];
                nxt.flag     = phv[phv_v6_flag_msb -: 16];
            end
            default: ;
        endcase
    end

    // **********************************************************
    // field capture
    // **********************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fields <= '0;
        end else if (cap_en) begin
            fields <= nxt;
        end
    end

endmodule

`default_nettype wire

/* design/gke_key_build.sv */
// key extractor stage 2 datapath
// packs the captured header fields into the 512-bit lookup key:
// a common ethernet/ip prefix, then a tail laid out per kind
// an unknown kind gives an all-zero key
`default_nettype none

module gke_key_build (
    input  wire                  logic      clk,
    input  wire                  logic      rst_n,
    input  wire gke_pkg::hdr_fields_t       fields,
    input  wire                  logic      s1_key_valid,
    input  wire gke_pkg::pkt_kind_e         s1_kind,
    output      gke_pkg::key_t              key,
    output      logic                       key_wr
);
    import gke_pkg::*;

    key_t key_nxt;

    always_comb begin
        key_nxt = '0;
        if (s1_kind != kind_other) begin
            key_nxt[key_dmac_lsb +: 48]     = fields.dmac;
            key_nxt[key_smac_lsb +: 48]     = fields.smac;
            key_nxt[key_tci_lsb +: 16]      = fields.tci;
            key_nxt[key_eth_type_lsb +: 16] = fields.eth_type;
            key_nxt[key_proto_lsb +: 8]     = fields.ip_proto;
            key_nxt[key_tos_lsb +: 8]       = fields.tos;
            key_nxt[key_ttl_lsb +: 8]       = fields.ttl;
            key_nxt[key_inport_lsb +: 6]    = fields.inport;
            key_nxt[key_frag_lsb +: 2]      = fields.frag;
        end
        case (s1_kind)
            kind_ipv4_l4, kind_ipv4: begin
                key_nxt[key_sip_lsb +: 32] = fields.sip;
                key_nxt[key_dip_lsb +: 32] = fields.dip;
                // ports and flags only when an l4 header is present
                if (s1_kind == kind_ipv4_l4) begin
                    key_nxt[key_v4_sport_lsb +: 16] = fields.sport;
                    key_nxt[key_v4_dport_lsb +: 16] = fields.dport;
                    key_nxt[key_v4_flag_lsb +: 16]  = fields.flag;
                end
            end
            kind_arp: begin
                key_nxt[key_sip_lsb +: 32]     = fields.sip;
                key_nxt[key_dip_lsb +: 32]     = fields.dip;
                key_nxt[key_arp_sha_lsb +: 48] = fields.sha;
                key_nxt[key_arp_tha_lsb +: 48] = fields.tha;
            end
            kind_ipv6_l4, kind_ipv6: begin
                key_nxt[key_v6_src_lsb +: 128]  = fields.src_ip;
                key_nxt[key_v6_dst_lsb +: 128]  = fields.dst_ip;
                key_nxt[key_v6_label_lsb +: 32] = fields.label;
                if (s1_kind == kind_ipv6_l4) begin
                    key_nxt[key_v6_sport_lsb +: 16] = fields.sport;
                    key_nxt[key_v6_dport_lsb +: 16] = fields.dport;
                end
            end
            default: begin
                key_nxt = '0;
            end
        endcase
    end

    // **********************************************************
    // key output register
    // **********************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key    <= '0;
            key_wr <= 1'b0;
        end else begin
            key_wr <= s1_key_valid;
            // idle cycles drive a zero key
            key    <= s1_key_valid ? key_nxt : '0;
        end
    end

endmodule

`default_nettype wire

/* design/gke_md_forward.sv */
// md and phv forwarding
// two register stages so that md and phv leave together with the
// key; a matched md gets the next stage's module id
`default_nettype none

module gke_md_forward #(
    parameter gke_pkg::mid_t next_mid = 8'd3
) (
    input  wire                logic        clk,
    input  wire                logic        rst_n,
    input  wire gke_pkg::md_t               md,
    input  wire                logic        md_wr,
    input  wire gke_pkg::phv_t              phv,
    input  wire                logic        phv_wr,
    input  wire                logic        s1_match,
    output      gke_pkg::md_t               out_md,
    output      logic                       out_md_wr,
    output      gke_pkg::phv_t              out_phv,
    output      logic                       out_phv_wr
);
    import gke_pkg::*;

    md_t  md_d1;
    phv_t phv_d1;
    logic md_wr_d1;
    logic phv_wr_d1;

    // first stage, payload
    always_ff @(posedge clk) begin
        md_d1  <= md;
        phv_d1 <= phv;
    end

    // first stage, strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            md_wr_d1  <= 1'b0;
            phv_wr_d1 <= 1'b0;
        end else begin
            md_wr_d1  <= md_wr;
            phv_wr_d1 <= phv_wr;
        end
    end

    // **********************************************************
    // second stage with module id rewrite
    // **********************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_md     <= '0;
            out_md_wr  <= 1'b0;
            out_phv    <= '0;
            out_phv_wr <= 1'b0;
        end else begin
            out_md_wr  <= md_wr_d1;
            out_phv_wr <= phv_wr_d1;
            out_phv    <= phv_wr_d1 ? phv_d1 : '0;
            if (!md_wr_d1) begin
                out_md <= '0;
            end else if (s1_match) begin
                out_md                    <= md_d1;
                out_md[md_mid_lsb +: 8]   <= next_mid;
            end else begin
                out_md <= md_d1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/gke_top.sv */
// generic key extractor, one pipeline stage
// takes md and phv from upstream, emits a lookup key for packets
// addressed to this stage and forwards md and phv two cycles later
`default_nettype none

module gke_top #(
    parameter gke_pkg::mid_t local_mid = 8'd2,
    parameter gke_pkg::mid_t next_mid  = 8'd3
) (
    input  wire                logic        clk,
    input  wire                logic        rst_n,
    input  wire gke_pkg::md_t               md,
    input  wire                logic        md_wr,
    input  wire gke_pkg::phv_t              phv,
    input  wire                logic        phv_wr,
    output wire                logic        md_alf,
    output wire                logic        phv_alf,
    output wire gke_pkg::key_t              key,
    output wire                logic        key_wr,
    input  wire                logic        down_key_alf,
    output wire gke_pkg::md_t               out_md,
    output wire                logic        out_md_wr,
    input  wire                logic        down_md_alf,
    output wire gke_pkg::phv_t              out_phv,
    output wire                logic        out_phv_wr,
    input  wire                logic        down_phv_alf
);
    import gke_pkg::*;

    logic        cap_en;
    pkt_kind_e   cap_kind;
    logic        s1_key_valid;
    pkt_kind_e   s1_kind;
    logic        s1_match;
    hdr_fields_t fields;

    gke_ctrl #(
        .local_mid (local_mid)
    ) i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .md           (md),
        .md_wr        (md_wr),
        .phv_wr       (phv_wr),
        .down_md_alf  (down_md_alf),
        .down_phv_alf (down_phv_alf),
        .down_key_alf (down_key_alf),
        .md_alf       (md_alf),
        .phv_alf      (phv_alf),
        .cap_en       (cap_en),
        .cap_kind     (cap_kind),
        .s1_key_valid (s1_key_valid),
        .s1_kind      (s1_kind),
        .s1_match     (s1_match)
    );

    gke_field_extract i_field_extract (
        .clk      (clk),
        .rst_n    (rst_n),
        .md       (md),
        .phv      (phv),
        .cap_en   (cap_en),
        .cap_kind (cap_kind),
        .fields   (fields)
    );

    gke_key_build i_key_build (
        .clk          (clk),
        .rst_n        (rst_n),
        .fields       (fields),
        .s1_key_valid (s1_key_valid),
        .s1_kind      (s1_kind),
        .key          (key),
        .key_wr       (key_wr)
    );

    gke_md_forward #(
        .next_mid (next_mid)
    ) i_md_forward (
        .clk        (clk),
        .rst_n      (rst_n),
        .md         (md),
        .md_wr      (md_wr),
        .phv        (phv),
        .phv_wr     (phv_wr),
        .s1_match   (s1_match),
        .out_md     (out_md),
        .out_md_wr  (out_md_wr),
        .out_phv    (out_phv),
        .out_phv_wr (out_phv_wr)
    );

endmodule

`default_nettype wire

/* verif/tb_gke_model.svh */
// reference model for the key extractor testbench
// builds the expected lookup key and the expected forwarded md
// from the header field positions and the key layout rules
`ifndef TB_GKE_MODEL_SVH
`define TB_GKE_MODEL_SVH

// key of one packet, all zero for kind_other
function automatic key_t expected_key(input md_t m, input phv_t p, input pkt_kind_e kind);
    key_t k;
    k = '0;
    if (kind == kind_other) begin
        return k;
    end
    // ethernet prefix and input port
    k[key_dmac_lsb +: 48]     = p[phv_dmac_msb -: 48];
    k[key_smac_lsb +: 48]     = p[phv_smac_msb -: 48];
    k[key_tci_lsb +: 16]      = p[phv_tci_msb -: 16];
    k[key_eth_type_lsb +: 16] = p[phv_eth_type_msb -: 16];
    k[key_inport_lsb +: 6]    = m[md_inport_lsb +: 6];
    case (kind)
        kind_ipv4_l4, kind_ipv4: begin
            k[key_proto_lsb +: 8] = p[phv_v4_proto_msb -: 8];
            k[key_tos_lsb +: 8]   = p[phv_v4_tos_msb -: 8];
            k[key_ttl_lsb +: 8]   = p[phv_v4_ttl_msb -: 8];
            k[key_frag_lsb +: 2]  = p[862:861];
            k[key_sip_lsb +: 32]  = p[phv_v4_sip_msb -: 32];
            k[key_dip_lsb +: 32]  = p[phv_v4_dip_msb -: 32];
            if (kind == kind_ipv4_l4) begin
                k[key_v4_sport_lsb +: 16] = p[phv_v4_sport_msb -: 16];
                k[key_v4_dport_lsb +: 16] = p[phv_v4_dport_msb -: 16];
                k[key_v4_flag_lsb +: 16]  = {10'b0, p[655:650]};
            end
        end
        kind_arp: begin
            // tos, ttl and frag stay zero for arp
            k[key_proto_lsb +: 8]      = p[855:848];
            k[key_sip_lsb +: 32]       = p[phv_arp_sip_msb -: 32];
            k[key_dip_lsb +: 32]       = p[phv_arp_dip_msb -: 32];
            k[key_arp_sha_lsb +: 48]   = p[phv_arp_sha_msb -: 48];
            k[key_arp_tha_lsb +: 48]   = p[phv_arp_tha_msb -: 48];
        end
        kind_ipv6_l4, kind_ipv6: begin
            k[key_proto_lsb +: 8]      = p[phv_v6_proto_msb -: 8];
            k[key_tos_lsb +: 8]        = p[phv_v6_tos_msb -: 8];
            k[key_ttl_lsb +: 8]        = p[phv_v6_ttl_msb -: 8];
            k[key_v6_src_lsb +: 128]   = p[phv_v6_src_msb -: 128];
            k[key_v6_dst_lsb +: 128]   = p[phv_v6_dst_msb -: 128];
            k[key_v6_label_lsb +: 32]  = {12'b0, p[899:880]};
            if (kind == kind_ipv6_l4) begin
                k[key_v6_sport_lsb +: 16] = p[phv_v6_sport_msb -: 16];
                k[key_v6_dport_lsb +: 16] = p[phv_v6_dport_msb -: 16];
            end
        end
        default: begin
            k = '0;
        end
    endcase
    return k;
endfunction

// forwarded md, module id handed on to the next stage when matched
function automatic md_t expected_md(input md_t m, input logic matched);
    md_t r;
    r = m;
    if (matched) begin
        r[87:80] = next_mid;
    end
    return r;
endfunction

`endif

/* verif/tb_gke.sv */
// testbench for the generic key extractor
// runs a table of packets through the DUT one at a time and then
// back to back, checks key, forwarded md and phv, and the alf paths
`default_nettype none

module tb_gke;
    import gke_pkg::*;

    // ids the DUT uses by default
    localparam mid_t local_mid = 8'd2;
    localparam mid_t next_mid  = 8'd3;
    localparam int   max_wait  = 10;

    logic clk;
    logic rst_n;
    md_t  md;
    logic md_wr;
    phv_t phv;
    logic phv_wr;
    logic md_alf;
    logic phv_alf;
    key_t key;
    logic key_wr;
    logic down_key_alf;
    md_t  out_md;
    logic out_md_wr;
    logic down_md_alf;
    phv_t out_phv;
    logic out_phv_wr;
    logic down_phv_alf;

    // stimulus table, one entry per row in each queue
    string      row_name[$];
    mid_t       row_mid[$];
    logic [7:0] row_code[$];
    logic       row_phv_wr[$];
    pkt_kind_e  row_kind[$];

    // every packet sent, in order
    md_t  sent_md[$];
    phv_t sent_phv[$];

    int errors;
    int tests;
    int failed_tests;
    int test_start_errors;

    `include "tb_gke_model.svh"

    gke_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .md           (md),
        .md_wr        (md_wr),
        .phv          (phv),
        .phv_wr       (phv_wr),
        .md_alf       (md_alf),
        .phv_alf      (phv_alf),
        .key          (key),
        .key_wr       (key_wr),
        .down_key_alf (down_key_alf),
        .out_md       (out_md),
        .out_md_wr    (out_md_wr),
        .down_md_alf  (down_md_alf),
        .out_phv      (out_phv),
        .out_phv_wr   (out_phv_wr),
        .down_phv_alf (down_phv_alf)
    );

    always #5 clk = ~clk;

    // **********************************************************
    // helpers
    // **********************************************************
    task automatic check_value(input string name, input logic [1023:0] expected,
                               input logic [1023:0] actual);
        if (actual !== expected) begin
            $display("Error %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %s ok", name);
        end else begin
            failed_tests++;
            $display("test %s FAILED", name);
        end
    endtask

    task automatic add_row(input string name, input mid_t mid, input logic [7:0] code,
                           input logic wr, input pkt_kind_e kind);
        row_name.push_back(name);
        row_mid.push_back(mid);
        row_code.push_back(code);
        row_phv_wr.push_back(wr);
        row_kind.push_back(kind);
    endtask

    task automatic load_table();
        add_row("ipv4_tcp",     8'd2, 8'h01, 1'b1, kind_ipv4_l4);
        add_row("ipv4_udp",     8'd2, 8'h07, 1'b1, kind_ipv4_l4);
        add_row("ipv4",         8'd2, 8'h02, 1'b1, kind_ipv4);
        add_row("arp",          8'd2, 8'h03, 1'b1, kind_arp);
        add_row("ipv6_tcp",     8'd2, 8'h81, 1'b1, kind_ipv6_l4);
        add_row("ipv6_udp",     8'd2, 8'h83, 1'b1, kind_ipv6_l4);
        add_row("ipv6",         8'd2, 8'h82, 1'b1, kind_ipv6);
        add_row("unknown_type", 8'd2, 8'h55, 1'b1, kind_other);
        add_row("no_phv",       8'd2, 8'h01, 1'b0, kind_other);
        add_row("other_stage",  8'd7, 8'h01, 1'b1, kind_other);
        add_row("after_other",  8'd2, 8'h81, 1'b1, kind_ipv6_l4);
    endtask

    function automatic md_t random_md(input mid_t mid, input logic [7:0] code);
        md_t m;
        for (int w = 0; w < 8; w++) begin
            m[w*32 +: 32] = $urandom;
        end
        m[md_mid_lsb +: 8]  = mid;
        m[md_type_lsb +: 8] = code;
        return m;
    endfunction

    function automatic phv_t random_phv();
        phv_t p;
        for (int w = 0; w < 32; w++) begin
            p[w*32 +: 32] = $urandom;
        end
        return p;
    endfunction

    task automatic drive_row(input int idx);
        md_t  m;
        phv_t p;
        m = random_md(row_mid[idx], row_code[idx]);
        p = random_phv();
        sent_md.push_back(m);
        sent_phv.push_back(p);
        md     = m;
        md_wr  = 1'b1;
        phv    = p;
        phv_wr = row_phv_wr[idx];
    endtask

    task automatic drive_idle();
        md     = '0;
        md_wr  = 1'b0;
        phv    = '0;
        phv_wr = 1'b0;
    endtask

    // outputs of table row idx, carried by sent packet pkt
    task automatic check_outputs(input string prefix, input int idx, input int pkt);
        string name;
        logic  matched;
        phv_t  exp_phv;
        name    = {prefix, row_name[idx]};
        matched = (row_mid[idx] == local_mid);
        exp_phv = row_phv_wr[idx] ? sent_phv[pkt] : '0;
        check_value({name, " out_md_wr"}, 1024'(1'b1), 1024'(out_md_wr));
        check_value({name, " key_wr"}, 1024'(matched), 1024'(key_wr));
        check_value({name, " key"},
                    1024'(expected_key(sent_md[pkt], sent_phv[pkt], row_kind[idx])),
                    1024'(key));
        check_value({name, " out_md"}, 1024'(expected_md(sent_md[pkt], matched)),
                    1024'(out_md));
        check_value({name, " out_phv_wr"}, 1024'(row_phv_wr[idx]), 1024'(out_phv_wr));
        check_value({name, " out_phv"}, exp_phv, out_phv);
    endtask

    // **********************************************************
    // tests
    // **********************************************************
    task automatic run_single(input int idx);
        int cycles;
        begin_test();
        @(posedge clk);
        #1;
        drive_row(idx);
        @(posedge clk);
        #1;
        drive_idle();
        cycles = 1;
        while (!out_md_wr && cycles < max_wait) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!out_md_wr) begin
            $display("Timeout waiting for out_md_wr in test %s", row_name[idx]);
            errors++;
        end else begin
            check_value({row_name[idx], " latency"}, 1024'(2), 1024'(cycles));
            check_outputs("", idx, sent_md.size() - 1);
        end
        end_test(row_name[idx]);
    endtask

    // whole table on consecutive cycles, outputs two cycles behind
    task automatic run_burst();
        int first;
        int n;
        first = sent_md.size();
        n     = row_name.size();
        begin_test();
        for (int k = 0; k < n + 2; k++) begin
            @(posedge clk);
            #1;
            if (k >= 2) begin
                check_outputs("burst ", k - 2, first + k - 2);
            end
            if (k < n) begin
                drive_row(k);
            end else begin
                drive_idle();
            end
        end
        end_test("back_to_back");
    endtask

    task automatic run_alf(input string name, input logic md_a, input logic phv_a,
                           input logic key_a);
        begin_test();
        @(posedge clk);
        #1;
        down_md_alf  = md_a;
        down_phv_alf = phv_a;
        down_key_alf = key_a;
        #1;
        check_value({name, " md_alf"}, 1024'(md_a | key_a), 1024'(md_alf));
        check_value({name, " phv_alf"}, 1024'(phv_a | key_a), 1024'(phv_alf));
        end_test(name);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        down_key_alf = 1'b0;
        down_md_alf  = 1'b0;
        down_phv_alf = 1'b0;
        drive_idle();
        void'($urandom(32'hd27c7231));
        load_table();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        begin_test();
        check_value("reset key_wr", 1024'(1'b0), 1024'(key_wr));
        check_value("reset out_md_wr", 1024'(1'b0), 1024'(out_md_wr));
        check_value("reset out_phv_wr", 1024'(1'b0), 1024'(out_phv_wr));
        check_value("reset key", 1024'(0), 1024'(key));
        check_value("reset out_md", 1024'(0), 1024'(out_md));
        check_value("reset out_phv", 1024'(0), out_phv);
        end_test("reset_values");

        for (int i = 0; i < row_name.size(); i++) begin
            run_single(i);
        end
        run_burst();
        run_alf("alf_md", 1'b1, 1'b0, 1'b0);
        run_alf("alf_phv", 1'b0, 1'b1, 1'b0);
        run_alf("alf_key", 1'b0, 1'b0, 1'b1);
        run_alf("alf_none", 1'b0, 1'b0, 1'b0);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verif
design/gke_pkg.sv
design/gke_ctrl.sv
design/gke_field_extract.sv
design/gke_key_build.sv
design/gke_md_forward.sv
design/gke_top.sv
verif/tb_gke.sv

/* Makefile */
# Verilator build and run for the generic key extractor testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_gke
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(wildcard design/*.sv) $(wildcard verif/*.sv) $(wildcard verif/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
